//--- controlUnit.f
+incdir+common
common/controlPkg.sv
rtl/instrClassifier.sv
rtl/interruptArbiter.sv
sequencer/stepSequencer.sv
sequencer/controlWordGen.sv
rtl/controlUnit.sv
verif/controlUnit_sva.sv
verif/controlUnit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
    --top-module controlUnit_tb \
    -f controlUnit.f \
    -o simv

# the simulator exits nonzero on $fatal, the log decides the result
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi

//--- verif/controlUnit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "control_params.svh"

module controlUnit_tb;

    localparam int nBranch = 64;        // random branch words
    localparam int nIo     = 8;         // out/in pairs
    localparam int nIrq    = 16;        // random request sets
    localparam int totalCycles = 8 + `START_DELAY + 2 + 22 + nIo * 3 + nBranch
                                 + (4 + nIrq) * 3 + 4;

    logic                     clk;
    logic                     rstN;
    controlPkg::instr_t       iMemOut;
    controlPkg::statusFlags_t flags;
    logic                     interruptEnable;
    controlPkg::irqMask_t     irqReq;
    controlPkg::ctrlWord_t    ctrl;
    controlPkg::addr_t        interruptVector;
    controlPkg::irqMask_t     irqClr;
    logic                     resetOut;

    logic [31:0] rngState = 32'hbe9cfd65;
    int          errCount = 0;

    controlUnit dut_i (
        .clk             (clk),
        .rstN            (rstN),
        .iMemOut         (iMemOut),
        .flags           (flags),
        .interruptEnable (interruptEnable),
        .irqReq          (irqReq),
        .ctrl            (ctrl),
        .interruptVector (interruptVector),
        .irqClr          (irqClr),
        .resetOut        (resetOut)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;      // 100 ns period

    // **************************************************
    // helpers
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic condTaken(input logic [2:0] cond,
                                       input controlPkg::statusFlags_t f);
        case (cond)
            3'd1:    return f.carry;
            3'd2:    return !f.carry;
            3'd3:    return f.zero;
            3'd4:    return !f.zero;
            3'd5:    return f.negative;
            3'd6:    return !f.negative;
            default: return 1'b1;       // always
        endcase
    endfunction

    // lowest set line wins
    function automatic controlPkg::irqMask_t winner(input controlPkg::irqMask_t r);
        return r & (~r + 1'b1);
    endfunction

    function automatic controlPkg::addr_t vectorOf(input controlPkg::irqMask_t r);
        case (winner(r))
            4'b0001: return 16'(`IRQ_VEC0);
            4'b0010: return 16'(`IRQ_VEC1);
            4'b0100: return 16'(`IRQ_VEC2);
            4'b1000: return 16'(`IRQ_VEC3);
            default: return '0;
        endcase
    endfunction

    // enables checked in every cycle
    function automatic controlPkg::ctrlWord_t enableCare();
        controlPkg::ctrlWord_t c;
        c = '0;
        c.regFileWriteEnable = 1'b1;
        c.dMemIOWriteEn      = 1'b1;
        c.dMemIOReadEn       = 1'b1;
        c.iMemReadEnable     = 1'b1;
        c.pcWriteEn          = 1'b1;
        return c;
    endfunction

    task automatic reportError(input string msg);
        errCount++;
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    // **************************************************
    // compare tasks
    task automatic checkCtrl(input string tag, input controlPkg::ctrlWord_t got,
                             input controlPkg::ctrlWord_t exp,
                             input controlPkg::ctrlWord_t care);
        if (((got ^ exp) & care) !== '0)
            reportError($sformatf("mismatch ctrl (%s): got %h expected %h care %h",
                                  tag, got, exp, care));
    endtask

    task automatic checkAddr(input string tag, input controlPkg::addr_t got,
                             input controlPkg::addr_t exp);
        if (got !== exp)
            reportError($sformatf("mismatch interruptVector (%s): got %h expected %h",
                                  tag, got, exp));
    endtask

    task automatic checkMask(input string tag, input controlPkg::irqMask_t got,
                             input controlPkg::irqMask_t exp);
        if (got !== exp)
            reportError($sformatf("mismatch irqClr (%s): got %h expected %h",
                                  tag, got, exp));
    endtask

    task automatic checkFlag(input string tag, input logic got, input logic exp);
        if (got !== exp)
            reportError($sformatf("mismatch resetOut (%s): got %h expected %h",
                                  tag, got, exp));
    endtask

    // drive on falling edge, settle before sampling
    task automatic driveCycle(input controlPkg::instr_t w,
                              input controlPkg::statusFlags_t f,
                              input logic ie, input controlPkg::irqMask_t r);
        @(negedge clk);
        iMemOut = w;
        flags = f;
        interruptEnable = ie;
        irqReq = r;
        #20;
    endtask

    // **************************************************
    // tests
    task automatic testPowerUp();
        controlPkg::ctrlWord_t exp;
        rstN = 1'b0;
        exp = '0;
        exp.iMemReadEnable = 1'b1;                          // fetch runs during start
        repeat (8) begin
            driveCycle('0, '0, 1'b0, '0);
            checkFlag("reset", resetOut, 1'b1);
            checkCtrl("reset", ctrl, exp, enableCare());
        end
        for (int i = 1; i <= `START_DELAY + 1; i++) begin
            @(negedge clk);
            rstN = 1'b1;
            #20;
            exp.pcWriteEn = (i == `START_DELAY + 1);       // first fetch
            checkFlag("hold", resetOut, 1'b1);
            checkCtrl("hold", ctrl, exp, enableCare());
        end
        driveCycle('0, '0, 1'b0, '0);                       // nop after start
        checkFlag("run", resetOut, 1'b0);
        checkCtrl("first nop", ctrl, exp, enableCare());
    endtask

    task automatic checkAluWord(input controlPkg::instr_t w, input controlPkg::aluMode_t mode,
                                input controlPkg::bSel_e bSel, input logic flagEn);
        controlPkg::ctrlWord_t exp;
        controlPkg::ctrlWord_t care;
        driveCycle(w, '0, 1'b0, '0);
        exp = '0;
        exp.regFileWriteEnable = 1'b1;
        exp.iMemReadEnable = 1'b1;
        exp.pcWriteEn = 1'b1;
        exp.aluMode = mode;
        exp.aluSrcBSelect = bSel;
        exp.flagEnable = flagEn;
        care = enableCare();
        care.aluMode = '1;
        care.aluSrcBSelect = controlPkg::bSel_e'(2'b11);
        care.flagEnable = 1'b1;
        checkCtrl("alu", ctrl, exp, care);
    endtask

    task automatic testAluOps();
        logic [31:0] r;
        for (int m = 1; m <= 7; m++) begin          // immediate, mode 1 is ldi
            r = nextRand();
            checkAluWord({r[15:4], 4'(m)}, 4'(m), controlPkg::IMM8, m != 1);
        end
        for (int m = 1; m <= 9; m++) begin          // reg-reg, mode 1 is mov
            r = nextRand();
            checkAluWord({r[15:8], 4'(m), 4'hA}, 4'(m), controlPkg::REG_B, m != 1);
        end
        for (int m = 10; m <= 15; m++) begin        // single register
            r = nextRand();
            checkAluWord({r[15:12], 4'h0, 4'(m), 4'hF}, 4'(m), controlPkg::REG_B, 1'b1);
        end
    endtask

    task automatic testIo();
        controlPkg::ctrlWord_t exp;
        controlPkg::ctrlWord_t care;
        logic [31:0] r;
        care = enableCare();
        care.dMemIOAddressSelect = controlPkg::dAddrSel_e'(2'b11);
        for (int i = 0; i < nIo; i++) begin
            r = nextRand();
            driveCycle({r[15:4], 4'h9}, '0, 1'b0, '0);     // out
            exp = '0;
            exp.dMemIOAddressSelect = controlPkg::IO_PORT;
            exp.dMemIOWriteEn = 1'b1;
            exp.iMemReadEnable = 1'b1;
            exp.pcWriteEn = 1'b1;
            checkCtrl("out", ctrl, exp, care);
            driveCycle({r[27:16], 4'h8}, '0, 1'b0, '0);    // in, read half
            exp = '0;
            exp.dMemIOAddressSelect = controlPkg::IO_PORT;
            exp.dMemIOReadEn = 1'b1;
            checkCtrl("in read", ctrl, exp, care);
            driveCycle({r[27:16], 4'h8}, '0, 1'b0, '0);    // write-back half
            exp.dMemIOReadEn = 1'b0;
            exp.regFileWriteEnable = 1'b1;
            exp.iMemReadEnable = 1'b1;
            exp.pcWriteEn = 1'b1;
            care.regFileSrc = 1'b1;
            exp.regFileSrc = 1'b1;
            checkCtrl("in write", ctrl, exp, care);
            care.regFileSrc = 1'b0;
        end
    endtask

    task automatic testBranches();
        controlPkg::ctrlWord_t exp;
        controlPkg::ctrlWord_t care;
        controlPkg::statusFlags_t f;
        controlPkg::instr_t w;
        logic [31:0] r;
        logic [2:0] cond;
        care = enableCare();
        care.iMemAddrSelect = controlPkg::iAddrSel_e'(3'b111);
        for (int i = 0; i < nBranch; i++) begin
            r = nextRand();
            f = controlPkg::statusFlags_t'(r[2:0]);
            cond = r[5:3];
            if (r[6])
                w = {cond, 1'b0, r[9:7], 9'h01F};          // register-indirect
            else
                w = {cond, r[16:8], 4'hE};                 // relative
            driveCycle(w, f, 1'b0, '0);
            exp = '0;
            exp.iMemReadEnable = 1'b1;
            exp.pcWriteEn = 1'b1;
            if (!condTaken(cond, f))
                exp.iMemAddrSelect = controlPkg::PC_NEXT;
            else if (r[6])
                exp.iMemAddrSelect = controlPkg::BRANCH_REG;
            else
                exp.iMemAddrSelect = controlPkg::BRANCH_REL;
            checkCtrl("branch", ctrl, exp, care);
        end
    endtask

    task automatic irqEntry(input controlPkg::irqMask_t req);
        controlPkg::ctrlWord_t exp;
        controlPkg::ctrlWord_t care;
        care = enableCare();
        exp = '0;
        exp.iMemReadEnable = 1'b1;
        exp.pcWriteEn = 1'b1;
        driveCycle('0, '0, 1'b0, req);                      // ie low, plain nop
        checkAddr("vector", interruptVector, vectorOf(req));
        checkMask("ie low", irqClr, '0);
        checkCtrl("ie low", ctrl, exp, care);
        care.regFileAdd = 1'b1;
        care.dMemDataSelect = controlPkg::dDataSel_e'(3'b111);
        care.iMemAddrSelect = controlPkg::iAddrSel_e'(3'b111);
        care.statusRegSrcSelect = controlPkg::srSel_e'(2'b11);
        care.flagEnable = 1'b1;
        exp.regFileAdd = 1'b1;
        exp.dMemIOWriteEn = 1'b1;
        exp.iMemAddrSelect = controlPkg::IRQ_VECTOR;
        exp.statusRegSrcSelect = controlPkg::DISABLE_IRQ;
        exp.flagEnable = 1'b1;                              // ie cleared on entry
        exp.dMemDataSelect = controlPkg::RET_LSB;          // low byte first
        exp.iMemReadEnable = 1'b0;
        exp.pcWriteEn = 1'b0;
        driveCycle('0, '0, 1'b1, req);
        checkMask("push lsb", irqClr, '0);
        checkCtrl("push lsb", ctrl, exp, care);
        exp.dMemDataSelect = controlPkg::RET_MSB;
        exp.iMemReadEnable = 1'b1;
        exp.pcWriteEn = 1'b1;
        driveCycle('0, '0, 1'b1, req);
        checkAddr("jump", interruptVector, vectorOf(req));
        checkMask("jump", irqClr, winner(req));
        checkCtrl("push msb", ctrl, exp, care);
    endtask

    task automatic testInterrupts();
        controlPkg::irqMask_t req;
        controlPkg::ctrlWord_t exp;
        logic [31:0] r;
        for (int i = 0; i < 4; i++)
            irqEntry(4'(1 << i));
        for (int i = 0; i < nIrq; i++) begin
            r = nextRand();
            req = r[3:0];
            if (req == '0)
                req = 4'b1000;
            irqEntry(req);
        end
        exp = '0;                                           // hlt spins, no entry
        repeat (3) begin
            driveCycle(16'hFFFF, '0, 1'b1, 4'b0001);
            checkMask("hlt", irqClr, '0);
            checkCtrl("hlt", ctrl, exp, enableCare());
        end
        driveCycle('0, '0, 1'b0, '0);
        checkAddr("no request", interruptVector, '0);
    endtask

    // **************************************************
    initial begin
        #(totalCycles * 200);
        reportError("timeout: tests did not finish in time");
    end

    initial begin
        rstN = 1'b0;
        iMemOut = '0;
        flags = '0;
        interruptEnable = 1'b0;
        irqReq = '0;
        testPowerUp();
        testAluOps();
        testIo();
        testBranches();
        testInterrupts();
        if (errCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- verif/controlUnit_sva.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit_sva (
    input wire                        clk,
    input wire                        rstN,
    input wire controlPkg::ctrlWord_t ctrl,
    input wire controlPkg::irqMask_t  irqClr,
    input wire                        resetOut
);

    // **************************************************
    // interrupt clear pulse
    clrOneHot: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0(irqClr))
        else $error("irqClr has more than one line set");

    clrWithJump: assert property (@(posedge clk) disable iff (!rstN)
        (irqClr != '0) |-> ctrl.pcWriteEn)
        else $error("irqClr pulsed without a pc write");

    // **************************************************
    // io bus direction
    ioOneDir: assert property (@(posedge clk) disable iff (!rstN)
        !(ctrl.dMemIOReadEn && ctrl.dMemIOWriteEn))
        else $error("io read and write enabled together");

    // no register writes while core is held
    resetNoWrite: assert property (@(posedge clk)
        resetOut |-> !ctrl.regFileWriteEnable)
        else $error("register write during core reset");

endmodule

bind controlUnit controlUnit_sva sva_i (
    .clk      (clk),
    .rstN     (rstN),
    .ctrl     (ctrl),
    .irqClr   (irqClr),
    .resetOut (resetOut)
);

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
    input  wire                           clk,
    input  wire                           rstN,
    input  wire controlPkg::instr_t       iMemOut,
    input  wire controlPkg::statusFlags_t flags,
    input  wire                           interruptEnable,
    input  wire controlPkg::irqMask_t     irqReq,
    output controlPkg::ctrlWord_t         ctrl,
    output controlPkg::addr_t             interruptVector,
    output controlPkg::irqMask_t          irqClr,
    output logic                          resetOut
);

    controlPkg::decoded_t decoded;      // combinational decode of iMemOut
    controlPkg::step_e    step;
    logic                 pending;      // any request line high
    logic                 inIrqStep;    // vector jump cycle
    logic                 takeIrq;      // entry starts this cycle
    logic                 delayDone;    // last power-up hold cycle

    // **************************************************
    instrClassifier classifier_i (
        .iMemOut (iMemOut),
        .flags   (flags),
        .decoded (decoded)
    );

    interruptArbiter arbiter_i (
        .irqReq          (irqReq),
        .inIrqStep       (inIrqStep),
        .interruptVector (interruptVector),
        .pending         (pending),
        .irqClr          (irqClr)
    );

    stepSequencer sequencer_i (
        .clk             (clk),
        .rstN            (rstN),
        .decoded         (decoded),
        .pending         (pending),
        .interruptEnable (interruptEnable),
        .step            (step),
        .takeIrq         (takeIrq),
        .inIrqStep       (inIrqStep),
        .delayDone       (delayDone),
        .resetOut        (resetOut)
    );

    controlWordGen ctrlGen_i (
        .step      (step),
        .decoded   (decoded),
        .iMemOut   (iMemOut),
        .takeIrq   (takeIrq),
        .delayDone (delayDone),
        .ctrl      (ctrl)
    );

endmodule

`default_nettype wire

//--- sequencer/controlWordGen.sv
`timescale 1ns/10ps
`default_nettype none

module controlWordGen (
    input  wire controlPkg::step_e    step,
    input  wire controlPkg::decoded_t decoded,
    input  wire controlPkg::instr_t   iMemOut,
    input  wire                       takeIrq,
    input  wire                       delayDone,
    output controlPkg::ctrlWord_t     ctrl
);

    logic pushStep;     // either half of interrupt entry

    assign pushStep = takeIrq || (step == controlPkg::IRQ_MSB);

    always_comb begin
        // **************************************************
        // defaults, nothing written
        ctrl.regFileSrc          = 1'b0;                    // alu out
        ctrl.regFileOutBSelect   = decoded.regSel;
        ctrl.regFileWriteEnable  = 1'b0;
        ctrl.regFileAdd          = 1'b0;
        ctrl.regFileConstSrc     = 2'b00;
        ctrl.aluSrcBSelect       = controlPkg::REG_B;
        ctrl.aluMode             = decoded.aluMode;
        ctrl.dMemDataSelect      = controlPkg::ALU_OUT;
        ctrl.dMemIOAddressSelect = controlPkg::PTR;
        ctrl.dMemIOWriteEn       = 1'b0;
        ctrl.dMemIOReadEn        = 1'b0;
        ctrl.statusRegSrcSelect  = controlPkg::ALU_FLAGS;
        ctrl.flagEnable          = 1'b0;
        ctrl.iMemAddrSelect      = controlPkg::PC_NEXT;
        ctrl.iMemReadEnable      = 1'b0;
        ctrl.pcWriteEn           = 1'b0;

        case (step)
            controlPkg::START: begin
                ctrl.statusRegSrcSelect = controlPkg::DISABLE_IRQ;  // ie off at boot
                ctrl.flagEnable         = 1'b1;
                ctrl.iMemReadEnable     = 1'b1;
                ctrl.pcWriteEn          = delayDone;                // first fetch
            end
            controlPkg::PART1: begin
                if (!takeIrq) begin
                    case (decoded.iClass)
                        controlPkg::ALU_IMM: begin
                            ctrl.regFileWriteEnable = 1'b1;
                            ctrl.aluSrcBSelect      = controlPkg::IMM8;
                            ctrl.flagEnable         = (iMemOut[2:0] != 3'd1);  // not ldi
                            ctrl.iMemReadEnable     = 1'b1;
                            ctrl.pcWriteEn          = 1'b1;
                        end
                        controlPkg::ALU_REG: begin
                            ctrl.regFileWriteEnable = 1'b1;
                            ctrl.flagEnable         = (iMemOut[7:4] != 4'd1);  // not mov
                            ctrl.iMemReadEnable     = 1'b1;
                            ctrl.pcWriteEn          = 1'b1;
                        end
                        controlPkg::IO: begin
                            ctrl.regFileSrc          = 1'b1;
                            ctrl.dMemIOAddressSelect = controlPkg::IO_PORT;
                            ctrl.dMemIOWriteEn       = !decoded.isIn;      // out
                            ctrl.dMemIOReadEn        = decoded.isIn;       // in, first half
                            ctrl.iMemReadEnable      = !decoded.isIn;
                            ctrl.pcWriteEn           = !decoded.isIn;
                        end
                        controlPkg::BRANCH: begin
                            if (!decoded.brTaken)
                                ctrl.iMemAddrSelect = controlPkg::PC_NEXT;
                            else if (decoded.brReg)
                                ctrl.iMemAddrSelect = controlPkg::BRANCH_REG;
                            else
                                ctrl.iMemAddrSelect = controlPkg::BRANCH_REL;
                            ctrl.iMemReadEnable = 1'b1;
                            ctrl.pcWriteEn      = 1'b1;
                        end
                        controlPkg::NOP_HLT: begin
                            ctrl.iMemReadEnable = !decoded.isHlt;          // hlt spins
                            ctrl.pcWriteEn      = !decoded.isHlt;
                        end
                        default: begin
                            ctrl.iMemReadEnable = 1'b1;                    // skip unknown
                            ctrl.pcWriteEn      = 1'b1;
                        end
                    endcase
                end
            end
            controlPkg::PART2: begin
                ctrl.regFileSrc          = 1'b1;                   // io data back
                ctrl.dMemIOAddressSelect = controlPkg::IO_PORT;
                ctrl.regFileWriteEnable  = 1'b1;
                ctrl.iMemReadEnable      = 1'b1;
                ctrl.pcWriteEn           = 1'b1;
            end
            default: ;      // irq_msb, handled below
        endcase

        // **************************************************
        // interrupt entry: push return address, sp decrements each half
        if (pushStep) begin
            ctrl.regFileOutBSelect  = 4'b1110;                      // sp low reg
            ctrl.regFileAdd         = 1'b1;
            ctrl.regFileConstSrc    = 2'b01;                        // sp--
            ctrl.dMemIOWriteEn      = 1'b1;
            ctrl.statusRegSrcSelect = controlPkg::DISABLE_IRQ;
            ctrl.flagEnable         = 1'b1;
            ctrl.iMemAddrSelect     = controlPkg::IRQ_VECTOR;
            ctrl.dMemDataSelect     = (step == controlPkg::IRQ_MSB) ? controlPkg::RET_MSB
                                                                    : controlPkg::RET_LSB;
            ctrl.iMemReadEnable     = (step == controlPkg::IRQ_MSB);   // jump on second half
            ctrl.pcWriteEn          = (step == controlPkg::IRQ_MSB);
        end
    end

endmodule

`default_nettype wire

//--- sequencer/stepSequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "control_params.svh"

module stepSequencer (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire controlPkg::decoded_t decoded,
    input  wire                       pending,
    input  wire                       interruptEnable,
    output controlPkg::step_e         step,
    output logic                      takeIrq,
    output logic                      inIrqStep,
    output logic                      delayDone,
    output logic                      resetOut
);

    localparam logic [`DELAY_W-1:0] delayLast = `START_DELAY;

    controlPkg::step_e   stepNext;
    logic [`DELAY_W-1:0] delayCnt;      // power-up hold counter

    // **************************************************
    // power-up delay
    assign delayDone = (step == controlPkg::START) && (delayCnt == delayLast);

    always_ff @(posedge clk) begin
        if (!rstN)
            delayCnt <= '0;
        else if ((step == controlPkg::START) && !delayDone)
            delayCnt <= delayCnt + 1'b1;
        else
            delayCnt <= '0;         // idle outside start
    end

    // **************************************************
    // interrupt entry only at instruction boundary, hlt not interruptible
    assign takeIrq   = (step == controlPkg::PART1) && interruptEnable && pending
                       && !decoded.isHlt;
    assign inIrqStep = (step == controlPkg::IRQ_MSB);
    assign resetOut  = (step == controlPkg::START);     // core held in reset

    always_comb begin
        case (step)
            controlPkg::START:
                stepNext = delayDone ? controlPkg::PART1 : controlPkg::START;
            controlPkg::PART1: begin
                if (takeIrq)
                    stepNext = controlPkg::IRQ_MSB;     // push msb, jump
                else if ((decoded.iClass == controlPkg::IO) && decoded.isIn)
                    stepNext = controlPkg::PART2;       // in writes back next cycle
                else
                    stepNext = controlPkg::PART1;
            end
            default:
                stepNext = controlPkg::PART1;           // part2, irq_msb
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN)
            step <= controlPkg::START;
        else
            step <= stepNext;
    end

endmodule

`default_nettype wire

//--- rtl/interruptArbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "control_params.svh"

module interruptArbiter (
    input  wire controlPkg::irqMask_t irqReq,
    input  wire                       inIrqStep,
    output controlPkg::addr_t         interruptVector,
    output logic                      pending,
    output controlPkg::irqMask_t      irqClr
);

    controlPkg::irqMask_t grant;    // one-hot winner

    // **************************************************
    // fixed priority, line 0 wins
    always_comb begin
        grant = '0;
        interruptVector = '0;       // no request
        if (irqReq[0]) begin
            grant[0] = 1'b1;
            interruptVector = controlPkg::addr_t'(`IRQ_VEC0);
        end else if (irqReq[1]) begin
            grant[1] = 1'b1;
            interruptVector = controlPkg::addr_t'(`IRQ_VEC1);
        end else if (irqReq[2]) begin
            grant[2] = 1'b1;
            interruptVector = controlPkg::addr_t'(`IRQ_VEC2);
        end else if (irqReq[3]) begin
            grant[3] = 1'b1;
            interruptVector = controlPkg::addr_t'(`IRQ_VEC3);
        end
    end

    assign pending = |irqReq;
    assign irqClr  = inIrqStep ? grant : '0;    // pulse only in vector step

endmodule

`default_nettype wire

//--- rtl/instrClassifier.sv
`timescale 1ns/10ps
`default_nettype none

`include "control_params.svh"

module instrClassifier (
    input  wire controlPkg::instr_t       iMemOut,
    input  wire controlPkg::statusFlags_t flags,
    output controlPkg::decoded_t          decoded
);

    logic [3:0] opc;            // class nibble
    logic [3:0] subOp;          // alu mode field of register ops
    logic isImm, isIo, isRegReg, isRegOne;
    logic isBrRel, isBrInd, nopWord, hltWord;
    logic condMet;

    assign opc   = iMemOut[3:0];
    assign subOp = iMemOut[7:4];

    // **************************************************
    // opcode patterns
    assign isImm    = (opc >= 4'd1) && (opc <= 4'd7);
    assign isIo     = (opc == `OPC_IN) || (opc == `OPC_OUT);
    assign isRegReg = (opc == `OPC_REGREG) && (subOp >= 4'd1) && (subOp <= 4'd9);
    assign isRegOne = (opc == `OPC_EXT) && (subOp >= 4'hA) && (iMemOut[11:8] == 4'h0);
    assign isBrRel  = (opc == `OPC_BRANCH);
    assign isBrInd  = (iMemOut[8:0] == {5'b0_0001, `OPC_EXT}) && !iMemOut[12];
    assign nopWord  = (iMemOut == '0);
    assign hltWord  = &iMemOut;     // all ones

    always_comb begin
        case (iMemOut[15:13])   // condition field
            3'd1:    condMet = flags.carry;
            3'd2:    condMet = !flags.carry;
            3'd3:    condMet = flags.zero;
            3'd4:    condMet = !flags.zero;
            3'd5:    condMet = flags.negative;
            3'd6:    condMet = !flags.negative;
            default: condMet = 1'b1;        // 0 and 7 always
        endcase
    end

    // **************************************************
    always_comb begin
        if (isImm)
            decoded.iClass = controlPkg::ALU_IMM;
        else if (isIo)
            decoded.iClass = controlPkg::IO;
        else if (isRegReg || isRegOne)
            decoded.iClass = controlPkg::ALU_REG;
        else if (isBrRel || isBrInd)
            decoded.iClass = controlPkg::BRANCH;
        else if (nopWord || hltWord)
            decoded.iClass = controlPkg::NOP_HLT;
        else
            decoded.iClass = controlPkg::NONE;      // unsupported, skipped
        decoded.isIn    = isIo && (opc == `OPC_IN);
        decoded.isHlt   = hltWord;
        decoded.brTaken = (isBrRel || isBrInd) && condMet;
        decoded.brReg   = iMemOut[0];               // odd encoding is indirect
        if (isImm)
            decoded.aluMode = {1'b0, iMemOut[2:0]};
        else if (isRegReg || isRegOne)
            decoded.aluMode = subOp;
        else
            decoded.aluMode = '0;                   // pass a
        // source reg for register ops, even half of pair otherwise
        decoded.regSel = (isRegReg || isRegOne) ? iMemOut[11:8] : {iMemOut[11:9], 1'b0};
    end

endmodule

`default_nettype wire

//--- common/controlPkg.sv
`default_nettype none

`include "control_params.svh"

package controlPkg;

    // **************************************************
    // plain vector types
    typedef logic [`INSTR_W-1:0]    instr_t;        // instruction word
    typedef logic [`ADDR_W-1:0]     addr_t;         // instruction address
    typedef logic [`ALU_MODE_W-1:0] aluMode_t;      // alu function
    typedef logic [3:0]             regSel_t;       // register file select
    typedef logic [`IRQ_N-1:0]      irqMask_t;      // one bit per request line

    // **************************************************
    // enums
    typedef enum logic [2:0] {
        NONE, ALU_IMM, ALU_REG, IO, BRANCH, NOP_HLT
    } instrClass_e;

    typedef enum logic [1:0] {
        START, PART1, PART2, IRQ_MSB
    } step_e;

    typedef enum logic [2:0] {
        PC_NEXT    = 3'b000,    // pc + 1
        IRQ_VECTOR = 3'b010,    // arbiter vector
        BRANCH_REG = 3'b100,    // register pair
        BRANCH_REL = 3'b110     // pc + offset
    } iAddrSel_e;

    typedef enum logic [1:0] {
        REG_B = 2'b00,          // register file port b
        IMM8  = 2'b10           // 8-bit immediate
    } bSel_e;

    typedef enum logic [1:0] {
        PTR     = 2'b00,        // register pointer, sp for pushes
        IO_PORT = 2'b01         // port number from instruction
    } dAddrSel_e;

    typedef enum logic [2:0] {
        ALU_OUT = 3'b000,
        RET_MSB = 3'b011,       // high byte of return address
        RET_LSB = 3'b100        // low byte of return address
    } dDataSel_e;

    typedef enum logic [1:0] {
        ALU_FLAGS   = 2'b00,    // flags from alu, ie kept
        DISABLE_IRQ = 2'b11     // clear ie, keep others
    } srSel_e;

    // **************************************************
    // structs
    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
    } statusFlags_t;

    typedef struct packed {
        instrClass_e iClass;
        logic        isIn;          // io class, read direction
        logic        isHlt;
        logic        brTaken;       // condition met
        logic        brReg;         // 1 register-indirect, 0 relative
        aluMode_t    aluMode;
        regSel_t     regSel;        // register b select
    } decoded_t;

    typedef struct packed {
        logic      regFileSrc;          // 0 alu, 1 data/io memory
        regSel_t   regFileOutBSelect;
        logic      regFileWriteEnable;
        logic      regFileAdd;          // pointer adjust
        logic [1:0] regFileConstSrc;    // 01 decrements
        bSel_e     aluSrcBSelect;
        aluMode_t  aluMode;
        dDataSel_e dMemDataSelect;
        dAddrSel_e dMemIOAddressSelect;
        logic      dMemIOWriteEn;
        logic      dMemIOReadEn;
        srSel_e    statusRegSrcSelect;
        logic      flagEnable;
        iAddrSel_e iMemAddrSelect;
        logic      iMemReadEnable;
        logic      pcWriteEn;
    } ctrlWord_t;

endpackage

`default_nettype wire

//--- common/control_params.svh
`ifndef CONTROL_PARAMS_SVH
`define CONTROL_PARAMS_SVH

// **************************************************
// widths
`define INSTR_W     16          // instruction word
`define ADDR_W      16          // instruction address
`define ALU_MODE_W  4           // alu function select
`define IRQ_N       4           // interrupt request lines

// power-up hold
`define START_DELAY 40          // cycles before first fetch
`define DELAY_W     6           // must hold START_DELAY

// interrupt vectors, line 0 highest priority
`define IRQ_VEC0    20
`define IRQ_VEC1    30
`define IRQ_VEC2    40
`define IRQ_VEC3    50

// **************************************************
// low-nibble class opcodes
`define OPC_IN      4'h8        // io read
`define OPC_OUT     4'h9        // io write
`define OPC_REGREG  4'hA        // register-register alu
`define OPC_BRANCH  4'hE        // relative branch
`define OPC_EXT     4'hF        // single-register alu, indirect branch

`endif
